//--- design/coreTypesPkg.sv
package coreTypesPkg;

    ////////////////////////////////////////
    // program counter
    ////////////////////////////////////////

    localparam int PC_W = 32;     // byte address width.

    typedef logic [PC_W-1:0] pcT;

    ////////////////////////////////////////
    // sequence numbers
    ////////////////////////////////////////

    // Age is taken from the sign of the wrap-around difference, so two
    // numbers being compared must stay within half of the range.
    localparam int SQN_W = 7;

    typedef logic [SQN_W-1:0] sqnT;

endpackage

//--- design/branchOpsPkg.sv
package branchOpsPkg;

    ////////////////////////////////////////
    // branch opcodes
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        BEQ  = 3'd0,    // equal.
        BNE  = 3'd1,    // not equal.
        BLT  = 3'd2,    // signed less than.
        BGE  = 3'd3,    // signed greater or equal.
        BLTU = 3'd4,    // unsigned less than.
        BGEU = 3'd5,    // unsigned greater or equal.
        JAL  = 3'd6     // unconditional jump.
    } branchOpT;

    ////////////////////////////////////////
    // instruction size
    ////////////////////////////////////////

    // fall-through step for a branch that is not taken.
    localparam int INSN_BYTES = 4;

endpackage

//--- design/branchUnit.sv
`timescale 1ns/1ns

module branchUnit
    import coreTypesPkg::*;
    import branchOpsPkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     issueValid,
    input  branchOpT op,
    input  pcT       srcA,
    input  pcT       srcB,
    input  pcT       pc,
    input  pcT       imm,
    input  logic     predTaken,
    input  sqnT      sqN,

    output logic     mispValid,
    output pcT       mispPc,
    output sqnT      mispSqN
);

    logic taken;
    logic mispredict;
    pcT   target;

    ////////////////////////////////////////
    // condition evaluation
    ////////////////////////////////////////

    always_comb begin
        case (op)
            BEQ:     taken = (srcA == srcB);
            BNE:     taken = (srcA != srcB);
            BLT:     taken = ($signed(srcA) < $signed(srcB));
            BGE:     taken = ($signed(srcA) >= $signed(srcB));
            BLTU:    taken = (srcA < srcB);
            BGEU:    taken = (srcA >= srcB);
            JAL:     taken = 1'b1;
            default: taken = 1'b0;      // unused encoding falls through.
        endcase
    end

    // corrected fetch address for the actual direction.
    assign target = taken ? (pc + imm) : (pc + pcT'(INSN_BYTES));

    assign mispredict = issueValid && (taken != predTaken);

    ////////////////////////////////////////
    // mispredict record
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mispValid <= 1'b0;
        end else begin
            mispValid <= mispredict;    // one cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        mispPc  <= target;
        mispSqN <= sqN;
    end

endmodule

//--- design/branchSelector.sv
`timescale 1ns/1ns

module branchSelector
    import coreTypesPkg::*;
#(
    parameter int numUnits = 3
) (
    input  logic clk,
    input  logic rst,

    input  logic mispValid [numUnits],
    input  pcT   mispPc    [numUnits],
    input  sqnT  mispSqN   [numUnits],

    input  logic trapValid,
    input  pcT   trapPc,
    input  sqnT  trapSqN,

    input  logic flushing,

    output logic redirValid,
    output pcT   redirPc,
    output sqnT  redirSqN,
    output logic fromBranch
);

    sqnT  flushSqN;
    logic unitValid;
    pcT   unitPc;
    sqnT  unitSqN;
    logic trapOk;

    // true when a is older than b.
    function automatic logic isOlder(input sqnT a, input sqnT b);
        sqnT diff;
        diff = a - b;
        return $signed(diff) < 0;
    endfunction

    // a slot passes when no flush runs or it predates the flushing one.
    function automatic logic passFlush(input sqnT s, input logic busy, input sqnT ref_);
        return !busy || isOlder(s, ref_);
    endfunction

    ////////////////////////////////////////
    // oldest eligible unit
    ////////////////////////////////////////

    always_comb begin
        unitValid = 1'b0;
        unitPc    = '0;
        unitSqN   = '0;
        for (int i = 0; i < numUnits; i++) begin
            if (mispValid[i] && passFlush(mispSqN[i], flushing, flushSqN) &&
                (!unitValid || isOlder(mispSqN[i], unitSqN))) begin
                unitValid = 1'b1;
                unitPc    = mispPc[i];
                unitSqN   = mispSqN[i];
            end
        end
    end

    ////////////////////////////////////////
    // trap override
    ////////////////////////////////////////

    assign trapOk = trapValid && passFlush(trapSqN, flushing, flushSqN);

    always_comb begin
        if (trapOk) begin
            redirValid = 1'b1;
            redirPc    = trapPc;
            redirSqN   = trapSqN;
            fromBranch = 1'b0;
        end else begin
            redirValid = unitValid;
            redirPc    = unitPc;
            redirSqN   = unitSqN;
            fromBranch = unitValid && !flushing;    // counts fresh mispredicts only.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flushSqN <= '0;
        end else if (redirValid) begin
            flushSqN <= redirSqN;       // newest issued redirect.
        end
    end

endmodule

//--- design/flushTracker.sv
`timescale 1ns/1ns

module flushTracker #(
    parameter int flushCycles = 4,
    parameter int cntW        = 16
) (
    input  logic            clk,
    input  logic            rst,

    input  logic            redirValid,
    input  logic            fromBranch,

    output logic            flushing,
    output logic [cntW-1:0] mispredCount
);

    localparam int timerW = $clog2(flushCycles + 1);

    logic [timerW-1:0] timer;

    ////////////////////////////////////////
    // flush window
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            timer <= '0;
        end else if (redirValid) begin
            timer <= timerW'(flushCycles);     // restart on every redirect.
        end else if (timer != '0) begin
            timer <= timer - 1'b1;
        end
    end

    assign flushing = (timer != '0);

    ////////////////////////////////////////
    // mispredict counter
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mispredCount <= '0;
        end else if (fromBranch && (mispredCount != '1)) begin
            mispredCount <= mispredCount + 1'b1;    // saturates at all ones.
        end
    end

endmodule

//--- design/branchResolve.sv
`timescale 1ns/1ns

module branchResolve
    import coreTypesPkg::*;
    import branchOpsPkg::*;
#(
    parameter int numUnits    = 3,
    parameter int flushCycles = 4,
    parameter int cntW        = 16
) (
    input  logic            clk,
    input  logic            rst,

    input  logic            issueValid [numUnits],
    input  branchOpT        op         [numUnits],
    input  pcT              srcA       [numUnits],
    input  pcT              srcB       [numUnits],
    input  pcT              pc         [numUnits],
    input  pcT              imm        [numUnits],
    input  logic            predTaken  [numUnits],
    input  sqnT             sqN        [numUnits],

    input  logic            trapValid,
    input  pcT              trapPc,
    input  sqnT             trapSqN,

    output logic            redirValid,
    output pcT              redirPc,
    output sqnT             redirSqN,
    output logic            flushing,
    output logic [cntW-1:0] mispredCount
);

    logic mispValid [numUnits];
    pcT   mispPc    [numUnits];
    sqnT  mispSqN   [numUnits];
    logic fromBranch;

    ////////////////////////////////////////
    // branch units
    ////////////////////////////////////////

    for (genvar u = 0; u < numUnits; u++) begin : genUnit
        branchUnit unit (
            .clk        (clk),
            .rst        (rst),
            .issueValid (issueValid[u]),
            .op         (op[u]),
            .srcA       (srcA[u]),
            .srcB       (srcB[u]),
            .pc         (pc[u]),
            .imm        (imm[u]),
            .predTaken  (predTaken[u]),
            .sqN        (sqN[u]),
            .mispValid  (mispValid[u]),
            .mispPc     (mispPc[u]),
            .mispSqN    (mispSqN[u])
        );
    end

    ////////////////////////////////////////
    // redirect selection and flush
    ////////////////////////////////////////

    branchSelector #(
        .numUnits (numUnits)
    ) selector (
        .clk        (clk),
        .rst        (rst),
        .mispValid  (mispValid),
        .mispPc     (mispPc),
        .mispSqN    (mispSqN),
        .trapValid  (trapValid),
        .trapPc     (trapPc),
        .trapSqN    (trapSqN),
        .flushing   (flushing),
        .redirValid (redirValid),
        .redirPc    (redirPc),
        .redirSqN   (redirSqN),
        .fromBranch (fromBranch)
    );

    flushTracker #(
        .flushCycles (flushCycles),
        .cntW        (cntW)
    ) tracker (
        .clk          (clk),
        .rst          (rst),
        .redirValid   (redirValid),
        .fromBranch   (fromBranch),
        .flushing     (flushing),
        .mispredCount (mispredCount)
    );

endmodule

//--- verif/branchResolveTb.sv
`timescale 1ns/1ns

module branchResolveTb
    import coreTypesPkg::*;
    import branchOpsPkg::*;
();

    localparam int numUnits    = 3;
    localparam int flushCycles = 4;
    localparam int cntW        = 16;
    localparam int testCycles  = 2000;
    localparam int resetCycles = 10;
    localparam int clkPeriod   = 4;
    localparam int timeoutNs   = 2 * (testCycles + resetCycles) * clkPeriod;

    logic            clk = 1'b0;
    logic            rst;
    logic            issueValid [numUnits];
    branchOpT        op         [numUnits];
    pcT              srcA       [numUnits];
    pcT              srcB       [numUnits];
    pcT              pc         [numUnits];
    pcT              imm        [numUnits];
    logic            predTaken  [numUnits];
    sqnT             sqN        [numUnits];
    logic            trapValid;
    pcT              trapPc;
    sqnT             trapSqN;
    logic            redirValid;
    pcT              redirPc;
    sqnT             redirSqN;
    logic            flushing;
    logic [cntW-1:0] mispredCount;

    integer seed = 32'ha2a2_5ffc;
    int     errors;
    int     checks;
    sqnT    seqBase;

    // reference model state.
    logic            refValid [numUnits];
    pcT              refPc    [numUnits];
    sqnT             refSqN   [numUnits];
    sqnT             refFlushSqN;
    int              refTimer;
    logic [cntW-1:0] refCount;
    logic            expValid;
    pcT              expPc;
    sqnT             expSqN;
    logic            expFromBranch;

    always #(clkPeriod / 2) clk = ~clk;

    branchResolve #(
        .numUnits    (numUnits),
        .flushCycles (flushCycles),
        .cntW        (cntW)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .issueValid   (issueValid),
        .op           (op),
        .srcA         (srcA),
        .srcB         (srcB),
        .pc           (pc),
        .imm          (imm),
        .predTaken    (predTaken),
        .sqN          (sqN),
        .trapValid    (trapValid),
        .trapPc       (trapPc),
        .trapSqN      (trapSqN),
        .redirValid   (redirValid),
        .redirPc      (redirPc),
        .redirSqN     (redirSqN),
        .flushing     (flushing),
        .mispredCount (mispredCount)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        return $random(seed);
    endfunction

    // a is older when b lies up to half the range ahead of it.
    function automatic logic olderThan(input sqnT a, input sqnT b);
        sqnT gap;
        gap = b - a;
        return (gap != 0) && (gap <= sqnT'(1 << (SQN_W - 1)));
    endfunction

    function automatic logic resolveTaken(input branchOpT o, input pcT a, input pcT b);
        logic signed [PC_W-1:0] sa;
        logic signed [PC_W-1:0] sb;
        sa = a;
        sb = b;
        case (o)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return sa < sb;
            BGE:     return !(sa < sb);
            BLTU:    return a < b;
            BGEU:    return !(a < b);
            JAL:     return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic checkVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////

    task automatic driveInputs(input int cyc);
        int density;
        density = ((cyc / 128) % 2 == 1) ? 3 : 1;   // alternate sparse and busy phases.
        if (cyc % 16 == 0) seqBase = sqnT'(seqBase + 1);
        for (int u = 0; u < numUnits; u++) begin
            issueValid[u] = (nextRand() % 4) < density;
            op[u]         = branchOpT'(3'(nextRand() % 7));
            srcA[u]       = nextRand();
            srcB[u]       = (nextRand() % 4 == 0) ? srcA[u] : nextRand();
            pc[u]         = nextRand() & ~32'h3;
            imm[u]        = nextRand() & ~32'h3;
            predTaken[u]  = nextRand() % 2 == 1;
            // distinct per unit so no two slots tie on age.
            sqN[u] = sqnT'(seqBase + (nextRand() % (32 / numUnits)) * numUnits + u);
        end
        trapValid = (nextRand() % 16) == 0;
        trapPc    = nextRand() & ~32'h3;
        trapSqN   = sqnT'(seqBase + nextRand() % 32);
    endtask

    task automatic computeExpected();
        logic flushNow;
        logic eligible [numUnits];
        logic oldest;
        logic trapOk;
        flushNow = (refTimer != 0);
        expValid = 1'b0;
        expPc    = '0;
        expSqN   = '0;
        for (int i = 0; i < numUnits; i++) begin
            eligible[i] = refValid[i] && (!flushNow || olderThan(refSqN[i], refFlushSqN));
        end
        for (int i = 0; i < numUnits; i++) begin
            oldest = eligible[i];
            for (int j = 0; j < numUnits; j++) begin
                if (j != i && eligible[j] && olderThan(refSqN[j], refSqN[i])) oldest = 1'b0;
            end
            if (oldest) begin
                expValid = 1'b1;
                expPc    = refPc[i];
                expSqN   = refSqN[i];
            end
        end
        expFromBranch = expValid && !flushNow;
        trapOk = trapValid && (!flushNow || olderThan(trapSqN, refFlushSqN));
        if (trapOk) begin
            expValid      = 1'b1;           // trap beats every unit.
            expPc         = trapPc;
            expSqN        = trapSqN;
            expFromBranch = 1'b0;
        end
    endtask

    task automatic advanceModel();
        logic taken;
        if (expValid) begin
            refFlushSqN = expSqN;
            refTimer    = flushCycles;
        end else if (refTimer > 0) begin
            refTimer--;
        end
        if (expFromBranch && refCount != '1) refCount++;
        for (int u = 0; u < numUnits; u++) begin
            taken       = resolveTaken(op[u], srcA[u], srcB[u]);
            refValid[u] = issueValid[u] && (taken != predTaken[u]);
            refPc[u]    = taken ? pc[u] + imm[u] : pc[u] + pcT'(INSN_BYTES);
            refSqN[u]   = sqN[u];
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        errors      = 0;
        checks      = 0;
        seqBase     = '0;
        rst         = 1'b1;
        trapValid   = 1'b0;
        trapPc      = '0;
        trapSqN     = '0;
        refFlushSqN = '0;
        refTimer    = 0;
        refCount    = '0;
        for (int u = 0; u < numUnits; u++) begin
            issueValid[u] = 1'b0;
            op[u]         = BEQ;
            srcA[u]       = '0;
            srcB[u]       = '0;
            pc[u]         = '0;
            imm[u]        = '0;
            predTaken[u]  = 1'b0;
            sqN[u]        = '0;
            refValid[u]   = 1'b0;
            refPc[u]      = '0;
            refSqN[u]     = '0;
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int cyc = 0; cyc < testCycles; cyc++) begin
            driveInputs(cyc);
            #1;                                     // let the selector settle.
            computeExpected();
            checkVal("redirValid", expValid, redirValid);
            if (expValid) begin
                checkVal("redirPc", expPc, redirPc);
                checkVal("redirSqN", expSqN, redirSqN);
            end
            checkVal("flushing", refTimer != 0, flushing);
            checkVal("mispredCount", refCount, mispredCount);
            advanceModel();
            @(negedge clk);
        end
        $display("checks: %0d, errors: %0d, mispredicts counted: %0d", checks, errors, refCount);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("watchdog timeout, the run did not finish within %0d ns", timeoutNs);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sources.f
design/coreTypesPkg.sv
design/branchOpsPkg.sv
design/branchUnit.sv
design/branchSelector.sv
design/flushTracker.sv
design/branchResolve.sv
verif/branchResolveTb.sv

//--- Makefile
TOP = branchResolveTb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir $(LOG)
